// ==== common/opreq_pkg.sv ====
// Instruction IDs, element widths and operand queue encodings
// Read and operand queue command structs, requester states
// Bank master numbering and arbitration groups

`default_nettype none

package opreq_pkg;

  // Instructions in flight and read requesters
  localparam int unsigned NrVInsn    = 4;
  localparam int unsigned NrOpQueues = 3;

  // Write-back sources, in the order they appear on the write-back port
  localparam int unsigned NrWbSrcs = 2;
  localparam int unsigned WbAlu    = 0;
  localparam int unsigned WbLdu    = 1;

  // Bank masters: the read requesters first, then the write-back sources
  localparam int unsigned NrMasters   = NrOpQueues + NrWbSrcs;
  localparam int unsigned MstIdxWidth = $clog2(NrMasters);
  localparam int unsigned MstAluWb    = NrOpQueues + WbAlu;
  localparam int unsigned MstLduWb    = NrOpQueues + WbLdu;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [6:0]                 vlen_t;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } ew_e;

  typedef enum logic [1:0] {
    OPQ_ALU_A,
    OPQ_ALU_B,
    OPQ_STORE
  } opqueue_e;

  // ALU operands and the ALU write always win over store reads and load writes
  localparam logic [NrMasters-1:0] HpMasters =
    NrMasters'((1 << OPQ_ALU_A) | (1 << OPQ_ALU_B) | (1 << MstAluWb));
  localparam logic [NrMasters-1:0] LpMasters =
    NrMasters'((1 << OPQ_STORE) | (1 << MstLduWb));

  typedef struct packed {
    vid_t               id;
    logic [2:0]         vs;
    vlen_t              vl;
    ew_e                ew;
    logic [NrVInsn-1:0] hazard;
  } opreq_cmd_t;

  typedef struct packed {
    ew_e   ew;
    vlen_t elem_count;
  } opq_cmd_t;

  typedef enum logic {
    REQ_IDLE,
    REQ_BUSY
  } req_state_e;

endpackage

`default_nettype wire

// ==== common/vrf_pkg.sv ====
// VRF geometry: banks, word width and address split
// Write-back request and bank access structs

`default_nettype none

package vrf_pkg;

  import opreq_pkg::*;

  localparam int unsigned NrBanks      = 4;
  localparam int unsigned BankSelWidth = $clog2(NrBanks);
  localparam int unsigned ElemWidth    = 64;
  localparam int unsigned VregWords    = 8;
  localparam int unsigned NrVregs      = 8;

  // Low bits pick the bank, the rest is the row inside the bank
  localparam int unsigned VrfAddrWidth = $clog2(NrVregs * VregWords);

  typedef logic [VrfAddrWidth-1:0]              vrf_addr_t;
  typedef logic [VrfAddrWidth-BankSelWidth-1:0] row_addr_t;
  typedef logic [ElemWidth-1:0]                 elem_t;
  typedef logic [ElemWidth/8-1:0]               strb_t;

  // Result word from a functional unit
  typedef struct packed {
    vid_t      id;
    vrf_addr_t addr;
    elem_t     wdata;
    strb_t     be;
  } vrf_write_t;

  // What a bank sees once a master wins it
  typedef struct packed {
    row_addr_t row;
    logic      wen;
    elem_t     wdata;
    strb_t     be;
    opqueue_e  opqueue;
  } vrf_access_t;

endpackage

`default_nettype wire

// ==== operand_requester_top.f ====
common/opreq_pkg.sv
common/vrf_pkg.sv
requester/operand_requester_fsm.sv
requester/writeback_port.sv
rtl/vrf_bank_arbiter.sv
rtl/operand_requester_top.sv
tests/tb_operand_requester.sv

// ==== requester/operand_requester_fsm.sv ====
// Operand requester for one operand queue
// Walks a vector register word by word and throttles on hazards

`timescale 1ns/1ns
`default_nettype none

module operand_requester_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  opreq_pkg::opqueue_e           queue_i,
  input  opreq_pkg::opreq_cmd_t         cmd_i,
  input  logic                          cmd_valid_i,
  output logic                          cmd_ready_o,
  input  logic                          opq_ready_i,
  output opreq_pkg::opq_cmd_t           opq_cmd_o,
  output logic                          opq_cmd_valid_o,
  input  logic [opreq_pkg::NrVInsn-1:0] insn_done_i,
  input  logic [opreq_pkg::NrVInsn-1:0] written_i,
  output logic [vrf_pkg::NrBanks-1:0]   bank_req_o,
  output vrf_pkg::vrf_access_t          access_o,
  input  logic [vrf_pkg::NrBanks-1:0]   bank_gnt_i,
  output logic                          issued_o
);

  import opreq_pkg::*;
  import vrf_pkg::*;

  req_state_e         state_d, state_q;
  vid_t               id_d, id_q;
  vrf_addr_t          addr_d, addr_q;
  vlen_t              len_d, len_q;
  ew_e                ew_d, ew_q;
  logic [NrVInsn-1:0] hazard_d, hazard_q;
  logic [NrVInsn-1:0] hazard_eff;
  vlen_t              per_word;
  logic               stall;

  // Elements packed in one 64-bit word
  assign per_word = vlen_t'(4'd8 >> ew_q);

  // An instruction never waits on its own results
  assign hazard_eff = hazard_q & ~(NrVInsn'(1) << id_q);

  // Read at most one word per result word the older instruction wrote last cycle
  assign stall = (|hazard_eff) && !(|(hazard_eff & written_i));

  assign issued_o  = |bank_gnt_i;
  assign opq_cmd_o = '{ew: cmd_i.ew, elem_count: cmd_i.vl};
  assign access_o  = '{
    row:     addr_q[VrfAddrWidth-1:BankSelWidth],
    wen:     1'b0,
    wdata:   '0,
    be:      '0,
    opqueue: queue_i
  };

  always_comb begin
    state_d         = state_q;
    id_d            = id_q;
    addr_d          = addr_q;
    len_d           = len_q;
    ew_d            = ew_q;
    hazard_d        = hazard_q;
    cmd_ready_o     = 1'b0;
    opq_cmd_valid_o = 1'b0;
    bank_req_o      = '0;

    case (state_q)
      REQ_IDLE: begin
        cmd_ready_o = 1'b1;
      end
      REQ_BUSY: begin
        if (opq_ready_i && !stall) begin
          bank_req_o[addr_q[BankSelWidth-1:0]] = 1'b1;
        end
        if (|bank_gnt_i) begin
          addr_d = addr_q + 1'b1;
          len_d  = (len_q > per_word) ? len_q - per_word : '0;
        end
        // Last word granted, so the next command may come in right now
        if (len_d == '0) begin
          state_d     = REQ_IDLE;
          cmd_ready_o = 1'b1;
        end
      end
      default: begin
        state_d = REQ_IDLE;
      end
    endcase

    if (cmd_valid_i && cmd_ready_o) begin
      id_d     = cmd_i.id;
      addr_d   = vrf_addr_t'(cmd_i.vs * VregWords);
      len_d    = cmd_i.vl;
      ew_d     = cmd_i.ew;
      hazard_d = cmd_i.hazard;
      // Empty vector: take it, but stay quiet
      if (cmd_i.vl != '0) begin
        state_d         = REQ_BUSY;
        opq_cmd_valid_o = 1'b1;
      end else begin
        state_d = REQ_IDLE;
      end
    end

    hazard_d = hazard_d & ~insn_done_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= REQ_IDLE;
      len_q    <= '0;
      hazard_q <= '0;
    end else begin
      state_q  <= state_d;
      len_q    <= len_d;
      hazard_q <= hazard_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q   <= id_d;
    addr_q <= addr_d;
    ew_q   <= ew_d;
  end

endmodule

`default_nettype wire

// ==== requester/writeback_port.sv ====
// Write-back sources for the ALU and the load unit
// Load stream register, delayed final grant, record of written IDs

`timescale 1ns/1ns
`default_nettype none

module writeback_port (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  vrf_pkg::vrf_write_t                                  alu_wb_i,
  input  logic                                                 alu_wb_req_i,
  output logic                                                 alu_wb_gnt_o,
  input  vrf_pkg::vrf_write_t                                  ldu_wb_i,
  input  logic                                                 ldu_wb_req_i,
  output logic                                                 ldu_wb_gnt_o,
  output logic                                                 ldu_wb_final_gnt_o,
  output logic [opreq_pkg::NrWbSrcs-1:0][vrf_pkg::NrBanks-1:0] bank_req_o,
  output vrf_pkg::vrf_access_t [opreq_pkg::NrWbSrcs-1:0]       access_o,
  input  logic [opreq_pkg::NrWbSrcs-1:0][vrf_pkg::NrBanks-1:0] bank_gnt_i,
  output logic [opreq_pkg::NrVInsn-1:0]                        written_o
);

  import opreq_pkg::*;
  import vrf_pkg::*;

  vrf_write_t         ldu_q;
  logic               ldu_valid_q;
  logic               ldu_gnt;
  logic [NrVInsn-1:0] written_d;

  function automatic vrf_access_t to_access(input vrf_write_t wr);
    return '{
      row:     wr.addr[VrfAddrWidth-1:BankSelWidth],
      wen:     1'b1,
      wdata:   wr.wdata,
      be:      wr.be,
      opqueue: OPQ_ALU_A
    };
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Load stream register

  // Granted only while requested, and the register is empty or draining
  assign ldu_gnt      = |bank_gnt_i[WbLdu];
  assign ldu_wb_gnt_o = ldu_wb_req_i && (!ldu_valid_q || ldu_gnt);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_valid_q <= 1'b0;
    end else if (ldu_wb_gnt_o) begin
      ldu_valid_q <= 1'b1;
    end else if (ldu_gnt) begin
      ldu_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_wb_gnt_o) begin
      ldu_q <= ldu_wb_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bank requests

  assign alu_wb_gnt_o    = |bank_gnt_i[WbAlu];
  assign access_o[WbAlu] = to_access(alu_wb_i);
  assign access_o[WbLdu] = to_access(ldu_q);

  always_comb begin
    bank_req_o = '0;
    bank_req_o[WbAlu][alu_wb_i.addr[BankSelWidth-1:0]] = alu_wb_req_i;
    bank_req_o[WbLdu][ldu_q.addr[BankSelWidth-1:0]]    = ldu_valid_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Written instructions and load final grant

  always_comb begin
    written_d = '0;
    written_d[alu_wb_i.id] = written_d[alu_wb_i.id] | alu_wb_gnt_o;
    written_d[ldu_q.id]    = written_d[ldu_q.id] | ldu_gnt;
  end

  // The load instruction is only done once its word is really in the bank
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_wb_final_gnt_o <= 1'b0;
      written_o          <= '0;
    end else begin
      ldu_wb_final_gnt_o <= ldu_gnt;
      written_o          <= written_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/operand_requester_top.sv ====
// Operand requester of one lane
// Three read requesters, write-back port and one arbiter per VRF bank

`timescale 1ns/1ns
`default_nettype none

module operand_requester_top (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  opreq_pkg::opreq_cmd_t [opreq_pkg::NrOpQueues-1:0] opreq_cmd_i,
  input  logic [opreq_pkg::NrOpQueues-1:0]                  opreq_valid_i,
  output logic [opreq_pkg::NrOpQueues-1:0]                  opreq_ready_o,
  input  logic [opreq_pkg::NrOpQueues-1:0]                  opq_ready_i,
  output opreq_pkg::opq_cmd_t [opreq_pkg::NrOpQueues-1:0]   opq_cmd_o,
  output logic [opreq_pkg::NrOpQueues-1:0]                  opq_cmd_valid_o,
  output logic [opreq_pkg::NrOpQueues-1:0]                  operand_issued_o,
  input  logic [opreq_pkg::NrVInsn-1:0]                     insn_done_i,
  input  vrf_pkg::vrf_write_t                               alu_wb_i,
  input  logic                                              alu_wb_req_i,
  output logic                                              alu_wb_gnt_o,
  input  vrf_pkg::vrf_write_t                               ldu_wb_i,
  input  logic                                              ldu_wb_req_i,
  output logic                                              ldu_wb_gnt_o,
  output logic                                              ldu_wb_final_gnt_o,
  output logic [vrf_pkg::NrBanks-1:0]                       vrf_req_o,
  output vrf_pkg::vrf_access_t [vrf_pkg::NrBanks-1:0]       vrf_access_o
);

  import opreq_pkg::*;
  import vrf_pkg::*;

  logic [NrOpQueues-1:0][NrBanks-1:0] opq_bank_req, opq_bank_gnt;
  logic [NrWbSrcs-1:0][NrBanks-1:0]   wb_bank_req, wb_bank_gnt;
  logic [NrBanks-1:0][NrMasters-1:0]  bank_req, bank_gnt;
  vrf_access_t [NrOpQueues-1:0]       opq_access;
  vrf_access_t [NrWbSrcs-1:0]         wb_access;
  vrf_access_t [NrMasters-1:0]        master_access;
  logic [NrVInsn-1:0]                 written;

  assign master_access = {wb_access, opq_access};

  ////////////////////////////////////////////////////////////////////////////
  // Master to bank transpose

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank_map
    for (genvar q = 0; q < NrOpQueues; q++) begin : gen_opq
      assign bank_req[b][q]     = opq_bank_req[q][b];
      assign opq_bank_gnt[q][b] = bank_gnt[b][q];
    end
    for (genvar w = 0; w < NrWbSrcs; w++) begin : gen_wb
      assign bank_req[b][NrOpQueues+w] = wb_bank_req[w][b];
      assign wb_bank_gnt[w][b]         = bank_gnt[b][NrOpQueues+w];
    end
  end

  for (genvar q = 0; q < NrOpQueues; q++) begin : gen_requester
    operand_requester_fsm requester_i (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .queue_i        (opqueue_e'(q)),
      .cmd_i          (opreq_cmd_i[q]),
      .cmd_valid_i    (opreq_valid_i[q]),
      .cmd_ready_o    (opreq_ready_o[q]),
      .opq_ready_i    (opq_ready_i[q]),
      .opq_cmd_o      (opq_cmd_o[q]),
      .opq_cmd_valid_o(opq_cmd_valid_o[q]),
      .insn_done_i    (insn_done_i),
      .written_i      (written),
      .bank_req_o     (opq_bank_req[q]),
      .access_o       (opq_access[q]),
      .bank_gnt_i     (opq_bank_gnt[q]),
      .issued_o       (operand_issued_o[q])
    );
  end

  writeback_port writeback_port_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .alu_wb_i          (alu_wb_i),
    .alu_wb_req_i      (alu_wb_req_i),
    .alu_wb_gnt_o      (alu_wb_gnt_o),
    .ldu_wb_i          (ldu_wb_i),
    .ldu_wb_req_i      (ldu_wb_req_i),
    .ldu_wb_gnt_o      (ldu_wb_gnt_o),
    .ldu_wb_final_gnt_o(ldu_wb_final_gnt_o),
    .bank_req_o        (wb_bank_req),
    .access_o          (wb_access),
    .bank_gnt_i        (wb_bank_gnt),
    .written_o         (written)
  );

  // Banks accept a granted access in the same cycle
  for (genvar b = 0; b < NrBanks; b++) begin : gen_arbiter
    vrf_bank_arbiter arbiter_i (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (bank_req[b]),
      .access_i    (master_access),
      .gnt_o       (bank_gnt[b]),
      .vrf_req_o   (vrf_req_o[b]),
      .vrf_access_o(vrf_access_o[b])
    );
  end

endmodule

`default_nettype wire

// ==== rtl/vrf_bank_arbiter.sv ====
// Arbiter for one VRF bank
// Round-robin inside two groups, high group always ahead of low group

`timescale 1ns/1ns
`default_nettype none

module vrf_bank_arbiter (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic [opreq_pkg::NrMasters-1:0]                      req_i,
  input  vrf_pkg::vrf_access_t [opreq_pkg::NrMasters-1:0]      access_i,
  output logic [opreq_pkg::NrMasters-1:0]                      gnt_o,
  output logic                                                 vrf_req_o,
  output vrf_pkg::vrf_access_t                                 vrf_access_o
);

  import opreq_pkg::*;

  logic [MstIdxWidth-1:0] hp_ptr_q, lp_ptr_q;
  logic [MstIdxWidth-1:0] next_ptr;
  logic [NrMasters-1:0]   hp_req, lp_req;
  logic [NrMasters-1:0]   hp_gnt, lp_gnt;

  // First requester at or after the pointer, wrapping around
  function automatic logic [NrMasters-1:0] rr_pick(
    input logic [NrMasters-1:0]   req,
    input logic [MstIdxWidth-1:0] ptr
  );
    logic [NrMasters-1:0] gnt;
    logic                 found;
    int unsigned          idx;
    gnt   = '0;
    found = 1'b0;
    for (int unsigned i = 0; i < NrMasters; i++) begin
      idx = (ptr + i) % NrMasters;
      if (!found && req[idx]) begin
        gnt[idx] = 1'b1;
        found    = 1'b1;
      end
    end
    return gnt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Grant selection

  assign hp_req = req_i & HpMasters;
  assign lp_req = req_i & LpMasters;
  assign hp_gnt = rr_pick(hp_req, hp_ptr_q);
  assign lp_gnt = rr_pick(lp_req, lp_ptr_q);

  // Low group only gets the bank when nobody in the high group wants it
  assign gnt_o     = (|hp_req) ? hp_gnt : lp_gnt;
  assign vrf_req_o = |req_i;

  always_comb begin
    vrf_access_o = '0;
    next_ptr     = '0;
    for (int unsigned m = 0; m < NrMasters; m++) begin
      if (gnt_o[m]) begin
        vrf_access_o = access_i[m];
        next_ptr     = MstIdxWidth'((m + 1) % NrMasters);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin pointers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hp_ptr_q <= '0;
      lp_ptr_q <= '0;
    end else if (|hp_req) begin
      hp_ptr_q <= next_ptr;
    end else if (|lp_req) begin
      lp_ptr_q <= next_ptr;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_operand_requester.sv ====
// Testbench for the operand requester top level
// Reference model of read streams and write-back, VRF bank monitor
// Six directed tests with random operands

`timescale 1ns/1ns
`default_nettype none

module tb_operand_requester;

  import opreq_pkg::*;
  import vrf_pkg::*;

  // Six tests at about 400 cycles each, plus margin
  localparam int unsigned TimeoutCycles = 4000;

  logic                         clk;
  logic                         rst_n;
  opreq_cmd_t [NrOpQueues-1:0]  opreq_cmd;
  logic [NrOpQueues-1:0]        opreq_valid;
  logic [NrOpQueues-1:0]        opreq_ready;
  logic [NrOpQueues-1:0]        opq_ready;
  opq_cmd_t [NrOpQueues-1:0]    opq_cmd;
  logic [NrOpQueues-1:0]        opq_cmd_valid;
  logic [NrOpQueues-1:0]        operand_issued;
  logic [NrVInsn-1:0]           insn_done;
  vrf_write_t                   alu_wb;
  logic                         alu_wb_req;
  logic                         alu_wb_gnt;
  vrf_write_t                   ldu_wb;
  logic                         ldu_wb_req;
  logic                         ldu_wb_gnt;
  logic                         ldu_final_gnt;
  logic [NrBanks-1:0]           vrf_req;
  vrf_access_t [NrBanks-1:0]    vrf_access;

  // Reference model state
  integer      seed;
  int unsigned cycle_cnt;
  int unsigned err_cnt;
  string       test_name;
  logic [2:0]  rd_vs   [NrOpQueues];
  int unsigned rd_cnt  [NrOpQueues];
  int unsigned rd_left [NrOpQueues];
  vrf_write_t  alu_exp [$];
  vrf_write_t  ldu_exp [$];
  int unsigned ldu_sent;
  int unsigned final_cnt;
  bit          hazard_watch;
  int unsigned haz_writes;

  operand_requester_top operand_requester_top_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .opreq_cmd_i       (opreq_cmd),
    .opreq_valid_i     (opreq_valid),
    .opreq_ready_o     (opreq_ready),
    .opq_ready_i       (opq_ready),
    .opq_cmd_o         (opq_cmd),
    .opq_cmd_valid_o   (opq_cmd_valid),
    .operand_issued_o  (operand_issued),
    .insn_done_i       (insn_done),
    .alu_wb_i          (alu_wb),
    .alu_wb_req_i      (alu_wb_req),
    .alu_wb_gnt_o      (alu_wb_gnt),
    .ldu_wb_i          (ldu_wb),
    .ldu_wb_req_i      (ldu_wb_req),
    .ldu_wb_gnt_o      (ldu_wb_gnt),
    .ldu_wb_final_gnt_o(ldu_final_gnt),
    .vrf_req_o         (vrf_req),
    .vrf_access_o      (vrf_access)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference functions

  // Words needed for vl elements of the given width
  function automatic int unsigned exp_words(input vlen_t vl, input ew_e ew);
    int unsigned per;
    per = 8 >> ew;
    return (vl + per - 1) / per;
  endfunction

  // Word address of the idx-th word of register vs
  function automatic vrf_addr_t exp_addr(input logic [2:0] vs, input int unsigned idx);
    return vrf_addr_t'(vs * VregWords + idx);
  endfunction

  function automatic opreq_cmd_t rand_cmd(input vid_t id, input logic [NrVInsn-1:0] hazard);
    opreq_cmd_t  c;
    int unsigned per;
    c.id     = id;
    c.vs     = $random(seed);
    c.ew     = ew_e'($random(seed));
    per      = 8 >> c.ew;
    c.vl     = vlen_t'(1 + ($unsigned($random(seed)) % (VregWords * per)));
    c.hazard = hazard;
    return c;
  endfunction

  function automatic vrf_write_t rand_write(input vid_t id);
    vrf_write_t wr;
    wr.id    = id;
    wr.addr  = $random(seed);
    wr.wdata = {$random(seed), $random(seed)};
    wr.be    = $random(seed);
    return wr;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Error handling

  task automatic stop_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_run($sformatf("mismatch test %s (%s) expected %0h actual %0h",
                         test_name, what, exp, act));
    end
  endtask

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt > TimeoutCycles) begin
        stop_run($sformatf("timeout: run did not finish within %0d cycles, stuck in test %s",
                           TimeoutCycles, test_name));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bank monitor

  always @(negedge clk) begin : bank_monitor
    logic [NrBanks-1:0] hp_want;
    int unsigned        q;
    vrf_addr_t          addr;
    vrf_write_t         wr;

    // Banks the high group asks for in this cycle, from the model
    hp_want = '0;
    for (int i = OPQ_ALU_A; i <= OPQ_ALU_B; i++) begin
      if (rd_left[i] != 0 && opq_ready[i]) begin
        addr = exp_addr(rd_vs[i], rd_cnt[i]);
        hp_want[addr[BankSelWidth-1:0]] = 1'b1;
      end
    end
    if (alu_wb_req) begin
      hp_want[alu_wb.addr[BankSelWidth-1:0]] = 1'b1;
    end

    for (int b = 0; b < NrBanks; b++) begin
      if (vrf_req[b] && !vrf_access[b].wen) begin
        q = vrf_access[b].opqueue;
        if (q >= NrOpQueues || rd_left[q] == 0) begin
          stop_run($sformatf("unexpected read on bank %0d for queue %0d in test %s",
                             b, q, test_name));
        end else begin
          addr = exp_addr(rd_vs[q], rd_cnt[q]);
          check("read bank", addr[BankSelWidth-1:0], b);
          check("read row", addr[VrfAddrWidth-1:BankSelWidth], vrf_access[b].row);
          check("operand issued", 1'b1, operand_issued[q]);
          if (q == OPQ_STORE) begin
            check("store read under high request", 1'b0, hp_want[b]);
            if (hazard_watch) begin
              check("store read within written words", 1'b1, rd_cnt[q] < haz_writes);
            end
          end
          rd_cnt[q]++;
          rd_left[q]--;
        end
      end else if (vrf_req[b] && alu_wb_gnt && alu_wb.addr[BankSelWidth-1:0] == b) begin
        if (alu_exp.size() == 0) begin
          stop_run($sformatf("ALU write on bank %0d with nothing pending", b));
        end else begin
          wr = alu_exp.pop_front();
          check("alu row", wr.addr[VrfAddrWidth-1:BankSelWidth], vrf_access[b].row);
          check("alu data", wr.wdata, vrf_access[b].wdata);
          check("alu be", wr.be, vrf_access[b].be);
        end
      end else if (vrf_req[b]) begin
        check("load write under high request", 1'b0, hp_want[b]);
        if (ldu_exp.size() == 0) begin
          stop_run($sformatf("load write on bank %0d with nothing pending", b));
        end else begin
          wr = ldu_exp.pop_front();
          check("load bank", wr.addr[BankSelWidth-1:0], b);
          check("load row", wr.addr[VrfAddrWidth-1:BankSelWidth], vrf_access[b].row);
          check("load data", wr.wdata, vrf_access[b].wdata);
          check("load be", wr.be, vrf_access[b].be);
        end
      end
    end

    // A requester is ready again only once its last word is granted
    for (int i = 0; i < NrOpQueues; i++) begin
      if (opreq_ready[i]) begin
        check("words left when ready", 0, rd_left[i]);
      end
    end

    // Writes count for the hazard only from the next cycle on
    if (hazard_watch && alu_wb_gnt && alu_wb.id == vid_t'(1)) begin
      haz_writes++;
    end
    if (ldu_final_gnt) begin
      final_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drivers

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Drive the staged commands of the queues in mask until each is taken
  task automatic issue_cmds(input logic [NrOpQueues-1:0] mask);
    logic [NrOpQueues-1:0] pending;
    logic [NrOpQueues-1:0] taken;
    pending     = mask;
    opreq_valid = mask;
    while (pending != '0) begin
      @(negedge clk);
      taken = pending & opreq_ready;
      for (int q = 0; q < NrOpQueues; q++) begin
        if (taken[q]) begin
          check("opq cmd valid", opreq_cmd[q].vl != '0, opq_cmd_valid[q]);
          if (opreq_cmd[q].vl != '0) begin
            check("opq elem_count", opreq_cmd[q].vl, opq_cmd[q].elem_count);
            check("opq ew", opreq_cmd[q].ew, opq_cmd[q].ew);
          end
        end
      end
      next_cycle();
      for (int q = 0; q < NrOpQueues; q++) begin
        if (taken[q]) begin
          rd_vs[q]   = opreq_cmd[q].vs;
          rd_cnt[q]  = 0;
          rd_left[q] = exp_words(opreq_cmd[q].vl, opreq_cmd[q].ew);
        end
      end
      pending     = pending & ~taken;
      opreq_valid = pending;
    end
  endtask

  task automatic alu_write(input vrf_write_t wr);
    alu_wb     = wr;
    alu_wb_req = 1'b1;
    alu_exp.push_back(wr);
    do begin
      @(negedge clk);
    end while (!alu_wb_gnt);
    next_cycle();
    alu_wb_req = 1'b0;
  endtask

  task automatic load_write(input vrf_write_t wr);
    ldu_wb     = wr;
    ldu_wb_req = 1'b1;
    ldu_exp.push_back(wr);
    ldu_sent++;
    do begin
      @(negedge clk);
    end while (!ldu_wb_gnt);
    next_cycle();
    ldu_wb_req = 1'b0;
  endtask

  // Run until every read stream and write has drained
  task automatic wait_idle(input bit jitter);
    bit busy;
    busy = 1'b1;
    while (busy) begin
      next_cycle();
      if (jitter) begin
        opq_ready = $random(seed);
      end
      busy = alu_exp.size() != 0 || ldu_exp.size() != 0;
      for (int q = 0; q < NrOpQueues; q++) begin
        if (rd_left[q] != 0 || !opreq_ready[q]) begin
          busy = 1'b1;
        end
      end
    end
    opq_ready = '1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    seed         = 76523;
    err_cnt      = 0;
    test_name    = "reset";
    clk          = 1'b0;
    rst_n        = 1'b0;
    opreq_cmd    = '0;
    opreq_valid  = '0;
    opq_ready    = '1;
    insn_done    = '0;
    alu_wb       = '0;
    alu_wb_req   = 1'b0;
    ldu_wb       = '0;
    ldu_wb_req   = 1'b0;
    ldu_sent     = 0;
    final_cnt    = 0;
    hazard_watch = 1'b0;
    haz_writes   = 0;
    for (int q = 0; q < NrOpQueues; q++) begin
      rd_vs[q]   = '0;
      rd_cnt[q]  = 0;
      rd_left[q] = 0;
    end

    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check("ready after reset", {NrOpQueues{1'b1}}, opreq_ready);
    check("controls after reset", '0,
          {opq_cmd_valid, operand_issued, alu_wb_gnt, ldu_wb_gnt, ldu_final_gnt, vrf_req});
    next_cycle();

    test_name = "alu_a_read";
    for (int n = 0; n < 4; n++) begin
      opreq_cmd[OPQ_ALU_A] = rand_cmd(vid_t'(0), '0);
      issue_cmds(3'b001);
      wait_idle(1'b1);
    end

    test_name = "empty_vl";
    opreq_cmd[OPQ_ALU_B]    = rand_cmd(vid_t'(1), '0);
    opreq_cmd[OPQ_ALU_B].vl = '0;
    issue_cmds(3'b010);
    repeat (4) next_cycle();
    check("ready after empty command", 1'b1, opreq_ready[OPQ_ALU_B]);

    // Every read stream starts on bank 0, so the queues collide
    test_name = "alu_contention";
    opreq_cmd[OPQ_ALU_A] = rand_cmd(vid_t'(0), '0);
    opreq_cmd[OPQ_ALU_B] = rand_cmd(vid_t'(1), '0);
    issue_cmds(3'b011);
    for (int n = 0; n < 12; n++) begin
      alu_write(rand_write(vid_t'(2)));
    end
    wait_idle(1'b0);

    test_name = "priority";
    opreq_cmd[OPQ_ALU_A] = rand_cmd(vid_t'(0), '0);
    opreq_cmd[OPQ_STORE] = rand_cmd(vid_t'(3), '0);
    issue_cmds(3'b101);
    for (int n = 0; n < 6; n++) begin
      load_write(rand_write(vid_t'(3)));
    end
    wait_idle(1'b0);

    test_name = "load_writes";
    for (int n = 0; n < 10; n++) begin
      load_write(rand_write(vid_t'($random(seed))));
    end
    wait_idle(1'b0);
    repeat (2) next_cycle();
    check("final grant pulses", ldu_sent, final_cnt);

    // Store waits on instruction 1 until it is marked done
    test_name    = "store_hazard";
    hazard_watch = 1'b1;
    opreq_cmd[OPQ_STORE]    = rand_cmd(vid_t'(2), 4'b0010);
    opreq_cmd[OPQ_STORE].ew = EW64;
    opreq_cmd[OPQ_STORE].vl = vlen_t'(VregWords);
    issue_cmds(3'b100);
    repeat (4) next_cycle();
    check("no read before writes", 0, rd_cnt[OPQ_STORE]);
    for (int n = 0; n < 3; n++) begin
      alu_write(rand_write(vid_t'(1)));
      repeat (2) next_cycle();
    end
    repeat (4) next_cycle();
    check("hazard writes", 3, haz_writes);
    check("reads during hazard", 3, rd_cnt[OPQ_STORE]);
    hazard_watch = 1'b0;
    insn_done    = 4'b0010;
    next_cycle();
    insn_done = '0;
    wait_idle(1'b0);

    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
